//--- hdl/mmu_pkg.sv
/* Sv32 types and constants shared by the MMU.
   Physical addresses are truncated to 32 bits, so PPN[1] bits 33:32 are never used. */
package mmu_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [19:0] vpn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [31:0] cause_t;
    typedef logic [1:0]  priv_t;

    // direct-mapped TLB geometry, one bank per access kind
    localparam int TLB_ENTRIES = 4;
    localparam int TLB_BANKS   = 3;
    localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);
    typedef logic [TLB_IDX_W-1:0]          tlb_idx_t;
    typedef logic [$bits(vpn_t)-TLB_IDX_W-1:0] tlb_tag_t;
    typedef logic [1:0]                    tlb_bank_t;

    typedef enum logic [1:0] {
        ACCESS_NONE  = 2'd0,
        ACCESS_CODE  = 2'd1,
        ACCESS_READ  = 2'd2,
        ACCESS_WRITE = 2'd3
    } access_t;

    localparam priv_t PRIV_U = 2'd0;
    localparam priv_t PRIV_S = 2'd1;
    localparam priv_t PRIV_M = 2'd3;

    localparam funct3_t FUNCT3_LW = 3'b010;

    localparam cause_t CAUSE_FETCH_PF = 32'd12;
    localparam cause_t CAUSE_LOAD_PF  = 32'd13;
    localparam cause_t CAUSE_STORE_PF = 32'd15;

    // PTE flag bits
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;

    localparam int MSTATUS_SUM   = 18;
    localparam int MSTATUS_MXR   = 19;
    localparam int SATP_MODE_BIT = 31;

    typedef enum logic [2:0] {
        WALK_IDLE,
        WALK_WAIT1,
        WALK_WAIT0,
        WALK_CHECK,
        WALK_UPDATE,
        WALK_FILL,
        WALK_FAULT
    } walk_state_t;

    // fetches translate the instruction address, loads and stores the data address
    function automatic xlen_t vaddr_of(access_t kind, xlen_t insn_addr, xlen_t data_addr);
        return (kind == ACCESS_CODE) ? insn_addr : data_addr;
    endfunction

    function automatic tlb_bank_t bank_of(access_t kind);
        case (kind)
            ACCESS_READ:  return 2'd1;
            ACCESS_WRITE: return 2'd2;
            default:      return 2'd0;
        endcase
    endfunction

    function automatic cause_t cause_of(access_t kind);
        case (kind)
            ACCESS_CODE: return CAUSE_FETCH_PF;
            ACCESS_READ: return CAUSE_LOAD_PF;
            default:     return CAUSE_STORE_PF;
        endcase
    endfunction

endpackage

//--- hdl/pte_mem_if.sv
/* Page walker requests toward the DRAM port.
   rd and wr are one-cycle strobes, only valid while own is high. */
interface pte_mem_if;
    import mmu_pkg::*;

    // walker holds the port
    logic  own;
    xlen_t addr;
    xlen_t wdata;
    logic  rd;
    logic  wr;

    modport walker (
        output own, addr, wdata, rd, wr
    );

    modport port (
        input own, addr, wdata, rd, wr
    );

endinterface

//--- hdl/tlb_fill_if.sv
/* One finished translation from the page walker into the TLB bank for kind.
   fill is a single-cycle pulse; kind NONE writes nothing. */
interface tlb_fill_if;
    import mmu_pkg::*;

    logic    fill;
    access_t kind;
    vpn_t    vpn;
    ppn_t    ppn;

    modport walker (
        output fill, kind, vpn, ppn
    );

    modport tlb (
        input fill, kind, vpn, ppn
    );

endinterface

//--- hdl/xlat_lookup.sv
/* Combinational Sv32 lookup over three direct-mapped TLBs, plus the M-mode/satp bypass.
   Fills and flushes land on the next edge; flush and fill must not coincide. */
module xlat_lookup (
    input  logic             CLK,
    input  logic             arst_n,
    input  mmu_pkg::access_t access,
    input  mmu_pkg::xlen_t   insn_addr,
    input  mmu_pkg::xlen_t   data_addr,
    input  mmu_pkg::priv_t   priv,
    input  mmu_pkg::xlen_t   satp,
    input  logic             flush,
    tlb_fill_if.tlb          fill,
    output mmu_pkg::xlen_t   paddr,
    output logic             ready,
    output logic             miss
);
    import mmu_pkg::*;

    logic [TLB_BANKS-1:0][TLB_ENTRIES-1:0] valid_q;
    tlb_tag_t tag_q [TLB_BANKS][TLB_ENTRIES];
    ppn_t     ppn_q [TLB_BANKS][TLB_ENTRIES];

    xlen_t     vaddr;
    vpn_t      vpn;
    tlb_idx_t  idx;
    tlb_bank_t bank;
    logic      bypass;
    logic      hit;
    logic      fill_we;
    tlb_bank_t fill_bank;
    tlb_idx_t  fill_idx;

    always_comb begin
        vaddr  = vaddr_of(access, insn_addr, data_addr);
        vpn    = vaddr[31:12];
        idx    = vpn[TLB_IDX_W-1:0];
        bank   = bank_of(access);
        bypass = (priv == PRIV_M) || !satp[SATP_MODE_BIT];
        // low vpn bits index, the rest is the tag
        hit    = (access != ACCESS_NONE) && valid_q[bank][idx]
                 && (tag_q[bank][idx] == vpn[$bits(vpn_t)-1:TLB_IDX_W]);
        paddr  = bypass ? vaddr : {ppn_q[bank][idx], vaddr[11:0]};
        ready  = bypass || hit;
        miss   = !bypass && (access != ACCESS_NONE) && !hit;
    end

    always_comb begin
        fill_we   = fill.fill && (fill.kind != ACCESS_NONE);
        fill_bank = bank_of(fill.kind);
        fill_idx  = fill.vpn[TLB_IDX_W-1:0];
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (fill_we) begin
            valid_q[fill_bank][fill_idx] <= 1'b1;
        end
    end

    // entry contents only matter once valid is set
    always_ff @(posedge CLK) begin
        if (fill_we) begin
            tag_q[fill_bank][fill_idx] <= fill.vpn[$bits(vpn_t)-1:TLB_IDX_W];
            ppn_q[fill_bank][fill_idx] <= fill.ppn;
        end
    end

    // the core's flush must never land on a walker fill
    fill_flush_excl: assert property (
        @(posedge CLK) disable iff (!arst_n) !(fill.fill && flush)
    );

endmodule

//--- hdl/pte_check.sv
/* Leaf decode and permission check of one Sv32 PTE for the given access.
   M-mode never reaches here, so any other priv code is treated as unrestricted. */
module pte_check (
    input  mmu_pkg::xlen_t   pte,
    input  mmu_pkg::access_t access,
    input  mmu_pkg::priv_t   priv,
    input  mmu_pkg::xlen_t   mstatus,
    output logic             valid,
    output logic             leaf,
    output logic             allowed,
    output logic             needs_update
);
    import mmu_pkg::*;

    logic readable;
    logic reserved;
    logic kind_ok;
    logic user_ok;

    always_comb begin
        valid    = pte[PTE_V];
        leaf     = pte[PTE_X] | pte[PTE_W] | pte[PTE_R];
        // mxr makes executable pages readable
        readable = pte[PTE_R] | (mstatus[MSTATUS_MXR] & pte[PTE_X]);
        reserved = pte[PTE_W] & ~pte[PTE_R];

        case (access)
            ACCESS_CODE:  kind_ok = pte[PTE_X];
            ACCESS_READ:  kind_ok = readable;
            ACCESS_WRITE: kind_ok = pte[PTE_W];
            default:      kind_ok = 1'b0;
        endcase

        // S-mode never fetches from user pages, SUM or not
        if (priv == PRIV_U) begin
            user_ok = pte[PTE_U];
        end else if (priv == PRIV_S) begin
            user_ok = !pte[PTE_U] || (mstatus[MSTATUS_SUM] && access != ACCESS_CODE);
        end else begin
            user_ok = 1'b1;
        end

        allowed      = kind_ok && user_ok && !reserved;
        needs_update = !pte[PTE_A] || (access == ACCESS_WRITE && !pte[PTE_D]);
    end

endmodule

//--- hdl/page_walker.sv
/* Two-level Sv32 walk on a TLB miss, with A/D write-back, TLB fill or page fault.
   The core must hold access, addresses, priv, satp and mstatus for the whole walk.
   Megapage PPN[0] alignment is not checked. */
module page_walker (
    input  logic             CLK,
    input  logic             arst_n,
    input  mmu_pkg::access_t access,
    input  mmu_pkg::xlen_t   insn_addr,
    input  mmu_pkg::xlen_t   data_addr,
    input  mmu_pkg::xlen_t   satp,
    input  mmu_pkg::xlen_t   mstatus,
    input  mmu_pkg::priv_t   priv,
    input  logic             miss,
    input  mmu_pkg::xlen_t   dram_rdata,
    input  logic             dram_busy,
    pte_mem_if.walker        mem,
    tlb_fill_if.walker       fill,
    output logic             page_fault,
    output mmu_pkg::cause_t  fault_cause
);
    import mmu_pkg::*;

    walk_state_t state_q;
    walk_state_t state_d;
    logic        lvl1_q;
    cause_t      cause_q;
    xlen_t       pte1_q;
    xlen_t       pte0_q;
    xlen_t       pte_addr_q;

    xlen_t vaddr;
    xlen_t pte1_in;
    xlen_t leaf_pte;
    xlen_t pte_wb;
    logic  stop1;
    logic  walk_ok;
    logic  valid1;
    logic  leaf1;
    logic  allowed1;
    logic  update1;
    logic  valid0;
    logic  leaf0;
    logic  allowed0;
    logic  update0;

    // level 1 is judged straight off the bus while its read completes
    assign pte1_in = (state_q == WALK_WAIT1) ? dram_rdata : pte1_q;

    pte_check u_chk1 (
        .pte          (pte1_in),
        .access       (access),
        .priv         (priv),
        .mstatus      (mstatus),
        .valid        (valid1),
        .leaf         (leaf1),
        .allowed      (allowed1),
        .needs_update (update1)
    );

    pte_check u_chk0 (
        .pte          (pte0_q),
        .access       (access),
        .priv         (priv),
        .mstatus      (mstatus),
        .valid        (valid0),
        .leaf         (leaf0),
        .allowed      (allowed0),
        .needs_update (update0)
    );

    always_comb begin
        vaddr    = vaddr_of(access, insn_addr, data_addr);
        stop1    = !valid1 || leaf1;
        leaf_pte = lvl1_q ? pte1_q : pte0_q;
        walk_ok  = lvl1_q ? (valid1 && leaf1 && allowed1) : (valid0 && leaf0 && allowed0);
        pte_wb   = leaf_pte;
        pte_wb[PTE_A] = 1'b1;
        if (access == ACCESS_WRITE) begin
            pte_wb[PTE_D] = 1'b1;
        end

        state_d   = state_q;
        mem.own   = 1'b0;
        mem.rd    = 1'b0;
        mem.wr    = 1'b0;
        // root table plus 4 * vpn[1]
        mem.addr  = {satp[19:0], vaddr[31:22], 2'b00};
        mem.wdata = pte_wb;
        fill.fill = 1'b0;
        fill.kind = access;
        fill.vpn  = vaddr[31:12];
        fill.ppn  = lvl1_q ? {pte1_q[29:20], vaddr[21:12]} : pte0_q[29:10];

        case (state_q)
            WALK_IDLE: begin
                if (miss && !dram_busy) begin
                    mem.own = 1'b1;
                    mem.rd  = 1'b1;
                    state_d = WALK_WAIT1;
                end
            end
            WALK_WAIT1: begin
                mem.own = 1'b1;
                if (!dram_busy) begin
                    if (stop1) begin
                        state_d = WALK_CHECK;
                    end else begin
                        mem.rd   = 1'b1;
                        mem.addr = {dram_rdata[29:10], vaddr[21:12], 2'b00};
                        state_d  = WALK_WAIT0;
                    end
                end
            end
            WALK_WAIT0: begin
                mem.own = 1'b1;
                if (!dram_busy) begin
                    state_d = WALK_CHECK;
                end
            end
            WALK_CHECK: begin
                mem.own = 1'b1;
                if (!walk_ok) begin
                    state_d = WALK_FAULT;
                end else if (!(lvl1_q ? update1 : update0)) begin
                    state_d = WALK_FILL;
                end else if (!dram_busy) begin
                    mem.wr   = 1'b1;
                    mem.addr = pte_addr_q;
                    state_d  = WALK_UPDATE;
                end
            end
            WALK_UPDATE: begin
                mem.own = 1'b1;
                if (!dram_busy) begin
                    state_d = WALK_FILL;
                end
            end
            WALK_FILL: begin
                fill.fill = 1'b1;
                state_d   = WALK_IDLE;
            end
            WALK_FAULT: begin
                if (access == ACCESS_NONE) begin
                    state_d = WALK_IDLE;
                end
            end
            default: begin
                state_d = WALK_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= WALK_IDLE;
            lvl1_q  <= 1'b0;
            cause_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == WALK_WAIT1 && !dram_busy) begin
                lvl1_q <= stop1;
            end
            if (state_q == WALK_CHECK) begin
                cause_q <= cause_of(access);
            end
        end
    end

    // captured PTEs and the address for write-back
    always_ff @(posedge CLK) begin
        if (mem.rd) begin
            pte_addr_q <= mem.addr;
        end
        if (state_q == WALK_WAIT1 && !dram_busy) begin
            pte1_q <= dram_rdata;
        end
        if (state_q == WALK_WAIT0 && !dram_busy) begin
            pte0_q <= dram_rdata;
        end
    end

    assign page_fault  = (state_q == WALK_FAULT);
    assign fault_cause = cause_q;

    strobe_when_idle: assert property (
        @(posedge CLK) disable iff (!arst_n) !((mem.rd || mem.wr) && dram_busy)
    );

endmodule

//--- hdl/dram_port.sv
/* Drives the DRAM port from the page walker or the translated core request.
   A core request is taken in a cycle with proc_busy low; its read data is
   valid once proc_busy falls again. A request held past that cycle is issued again. */
module dram_port (
    input  mmu_pkg::access_t access,
    input  logic             data_we,
    input  mmu_pkg::xlen_t   data_wdata,
    input  mmu_pkg::funct3_t data_ctrl,
    input  mmu_pkg::xlen_t   paddr,
    input  logic             ready,
    input  logic             miss,
    pte_mem_if.port          mem,
    input  logic             dram_busy,
    output mmu_pkg::xlen_t   dram_addr,
    output mmu_pkg::xlen_t   dram_wdata,
    output logic             dram_we,
    output logic             dram_le,
    output mmu_pkg::funct3_t dram_ctrl,
    output logic             proc_busy
);
    import mmu_pkg::*;

    logic go;

    always_comb begin
        // translation done and memory free
        go = ready && !dram_busy;

        if (mem.own) begin
            // PTE traffic is always whole words
            dram_addr  = mem.addr;
            dram_wdata = mem.wdata;
            dram_le    = mem.rd;
            dram_we    = mem.wr;
            dram_ctrl  = FUNCT3_LW;
        end else begin
            dram_addr  = paddr;
            dram_wdata = data_wdata;
            dram_le    = go && (access == ACCESS_CODE || access == ACCESS_READ);
            dram_we    = go && (access == ACCESS_WRITE) && data_we;
            // fetches are word sized whatever data_ctrl says
            dram_ctrl  = (access == ACCESS_CODE) ? FUNCT3_LW : data_ctrl;
        end

        proc_busy = mem.own || miss || dram_busy;
    end

endmodule

//--- hdl/sv32_mmu.sv
/* Sv32 MMU between a RISC-V core and one word-wide DRAM port.
   Single hart only; the DRAM must raise busy on the edge after each strobe. */
module sv32_mmu (
    input  logic             CLK,
    input  logic             arst_n,
    // core side
    input  mmu_pkg::access_t access,
    input  mmu_pkg::xlen_t   insn_addr,
    input  mmu_pkg::xlen_t   data_addr,
    input  mmu_pkg::xlen_t   data_wdata,
    input  logic             data_we,
    input  mmu_pkg::funct3_t data_ctrl,
    input  mmu_pkg::priv_t   priv,
    input  mmu_pkg::xlen_t   satp,
    input  mmu_pkg::xlen_t   mstatus,
    input  logic             tlb_flush,
    output mmu_pkg::xlen_t   insn_data,
    output logic             proc_busy,
    output logic             page_fault,
    output mmu_pkg::cause_t  fault_cause,
    // memory side
    output mmu_pkg::xlen_t   dram_addr,
    output mmu_pkg::xlen_t   dram_wdata,
    output logic             dram_we,
    output logic             dram_le,
    output mmu_pkg::funct3_t dram_ctrl,
    input  mmu_pkg::xlen_t   dram_rdata,
    input  logic             dram_busy
);
    import mmu_pkg::*;

    xlen_t paddr;
    logic  ready;
    logic  miss;

    pte_mem_if  pte_mem ();
    tlb_fill_if tlb_fill ();

    assign insn_data = dram_rdata;

    xlat_lookup u_lookup (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .access    (access),
        .insn_addr (insn_addr),
        .data_addr (data_addr),
        .priv      (priv),
        .satp      (satp),
        .flush     (tlb_flush),
        .fill      (tlb_fill.tlb),
        .paddr     (paddr),
        .ready     (ready),
        .miss      (miss)
    );

    page_walker u_walker (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .access      (access),
        .insn_addr   (insn_addr),
        .data_addr   (data_addr),
        .satp        (satp),
        .mstatus     (mstatus),
        .priv        (priv),
        .miss        (miss),
        .dram_rdata  (dram_rdata),
        .dram_busy   (dram_busy),
        .mem         (pte_mem.walker),
        .fill        (tlb_fill.walker),
        .page_fault  (page_fault),
        .fault_cause (fault_cause)
    );

    dram_port u_port (
        .access     (access),
        .data_we    (data_we),
        .data_wdata (data_wdata),
        .data_ctrl  (data_ctrl),
        .paddr      (paddr),
        .ready      (ready),
        .miss       (miss),
        .mem        (pte_mem.port),
        .dram_busy  (dram_busy),
        .dram_addr  (dram_addr),
        .dram_wdata (dram_wdata),
        .dram_we    (dram_we),
        .dram_le    (dram_le),
        .dram_ctrl  (dram_ctrl),
        .proc_busy  (proc_busy)
    );

endmodule

//--- tests/tb_dram_model.sv
/* Word-wide DRAM model for the MMU testbench, byte addresses and whole words only.
   Busy lasts 1 to 4 cycles after each strobe; unwritten words read as an address pattern. */
module tb_dram_model (
    input  logic           CLK,
    input  logic           arst_n,
    input  mmu_pkg::xlen_t addr,
    input  mmu_pkg::xlen_t wdata,
    input  logic           we,
    input  logic           le,
    output mmu_pkg::xlen_t rdata,
    output logic           busy
);
    import mmu_pkg::*;

    localparam logic [15:0] LFSR_SEED = 16'd45137;

    xlen_t       words [xlen_t];
    logic [15:0] lfsr_q;
    logic [15:0] lfsr_1;
    logic [15:0] lfsr_2;
    logic [1:0]  left_q;

    // fibonacci taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // backdoor read, used by the tests as well
    function automatic xlen_t peek(xlen_t byte_addr);
        if (words.exists(byte_addr >> 2)) begin
            return words[byte_addr >> 2];
        end
        return {byte_addr[15:0], byte_addr[31:16]} ^ 32'h5a5a_a5a5;
    endfunction

    task automatic poke(xlen_t byte_addr, xlen_t data);
        words[byte_addr >> 2] = data;
    endtask

    assign lfsr_1 = lfsr_step(lfsr_q);
    assign lfsr_2 = lfsr_step(lfsr_1);

    always @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            lfsr_q <= LFSR_SEED;
            busy   <= 1'b0;
            left_q <= 2'd0;
            rdata  <= '0;
        end else if (!busy && (le || we)) begin
            // one new bit per step, two bits per strobe
            lfsr_q <= lfsr_2;
            left_q <= {lfsr_1[0], lfsr_2[0]};
            busy   <= 1'b1;
            if (le) begin
                rdata <= peek(addr);
            end
            if (we) begin
                poke(addr, wdata);
            end
        end else if (busy) begin
            if (left_q == 2'd0) begin
                busy <= 1'b0;
            end else begin
                left_q <= left_q - 2'd1;
            end
        end
    end

endmodule

//--- tests/tb_sv32_mmu.sv
/* Directed tests of the Sv32 MMU against the DRAM model.
   Root table at 0x10000, level-0 table at 0x11000; all accesses are whole words. */
module tb_sv32_mmu;
    import mmu_pkg::*;

    localparam int        WAIT_LIMIT = 100;
    localparam xlen_t     SATP_ON    = 32'h8000_0010;
    localparam xlen_t     ROOT_PA    = 32'h0001_0000;
    localparam xlen_t     L0_PA      = 32'h0001_1000;
    // byte size, driven on fetches to show it is ignored there
    localparam funct3_t   BYTE_CTRL  = 3'b000;
    localparam logic [7:0] F_V = 8'h01;
    localparam logic [7:0] F_R = 8'h02;
    localparam logic [7:0] F_W = 8'h04;
    localparam logic [7:0] F_X = 8'h08;
    localparam logic [7:0] F_U = 8'h10;
    localparam logic [7:0] F_A = 8'h40;
    localparam logic [7:0] F_D = 8'h80;

    logic    CLK = 1'b0;
    logic    arst_n;
    access_t access;
    xlen_t   insn_addr;
    xlen_t   data_addr;
    xlen_t   data_wdata;
    logic    data_we;
    funct3_t data_ctrl;
    priv_t   priv;
    xlen_t   satp;
    xlen_t   mstatus;
    logic    tlb_flush;
    xlen_t   insn_data;
    logic    proc_busy;
    logic    page_fault;
    cause_t  fault_cause;
    xlen_t   dram_addr;
    xlen_t   dram_wdata;
    logic    dram_we;
    logic    dram_le;
    funct3_t dram_ctrl;
    xlen_t   dram_rdata;
    logic    dram_busy;

    int     errors  = 0;
    int     le_seen = 0;
    string  test_name = "reset";
    // result of the last access
    logic    res_fault;
    cause_t  res_cause;
    xlen_t   res_addr;
    xlen_t   res_wdata;
    xlen_t   res_data;
    funct3_t res_ctrl;
    logic    res_le;
    logic    res_we;
    int      res_ptes;

    always #10 CLK = ~CLK;

    sv32_mmu dut0 (
        .CLK (CLK), .arst_n (arst_n), .access (access), .insn_addr (insn_addr),
        .data_addr (data_addr), .data_wdata (data_wdata), .data_we (data_we),
        .data_ctrl (data_ctrl), .priv (priv), .satp (satp), .mstatus (mstatus),
        .tlb_flush (tlb_flush), .insn_data (insn_data), .proc_busy (proc_busy),
        .page_fault (page_fault), .fault_cause (fault_cause), .dram_addr (dram_addr),
        .dram_wdata (dram_wdata), .dram_we (dram_we), .dram_le (dram_le),
        .dram_ctrl (dram_ctrl), .dram_rdata (dram_rdata), .dram_busy (dram_busy)
    );

    tb_dram_model mem0 (
        .CLK (CLK), .arst_n (arst_n), .addr (dram_addr), .wdata (dram_wdata),
        .we (dram_we), .le (dram_le), .rdata (dram_rdata), .busy (dram_busy)
    );

    // read strobes taken by the memory
    always @(posedge CLK) begin
        if (dram_le) begin
            le_seen <= le_seen + 1;
        end
    end

    function automatic xlen_t pte_of(ppn_t ppn, logic [7:0] flags);
        return {2'b00, ppn, 2'b00, flags};
    endfunction

    task automatic finish_run();
        $display("Error count: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout in test %s while waiting for %s", test_name, what);
        finish_run();
    endtask

    task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s %s got %h expected %h", $time, test_name, what, got, exp);
        end
    endtask

    task automatic check_cause(input cause_t got, input cause_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s %s got cause %0d expected %0d",
                     $time, test_name, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s %s got %b expected %b", $time, test_name, what, got, exp);
        end
    endtask

    task automatic check_ctrl(input funct3_t got, input funct3_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s %s got %b expected %b", $time, test_name, what, got, exp);
        end
    endtask

    task automatic set_mode(input priv_t p, input xlen_t s, input xlen_t m);
        @(posedge CLK);
        priv    <= p;
        satp    <= s;
        mstatus <= m;
    endtask

    // one core access, held until taken or faulted, then dropped
    task automatic do_access(input access_t kind, input xlen_t va, input xlen_t wd);
        int waited;
        int reads0;
        reads0 = le_seen;
        @(posedge CLK);
        access     <= kind;
        insn_addr  <= va;
        data_addr  <= va;
        data_wdata <= wd;
        data_we    <= (kind == ACCESS_WRITE);
        data_ctrl  <= (kind == ACCESS_CODE) ? BYTE_CTRL : FUNCT3_LW;
        waited = 0;
        @(negedge CLK);
        while (proc_busy && !page_fault) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("translation");
            end
            @(negedge CLK);
        end
        res_fault = page_fault;
        res_cause = fault_cause;
        res_addr  = dram_addr;
        res_wdata = dram_wdata;
        res_ctrl  = dram_ctrl;
        res_le    = dram_le;
        res_we    = dram_we;
        res_ptes  = le_seen - reads0;
        @(posedge CLK);
        access  <= ACCESS_NONE;
        data_we <= 1'b0;
        waited = 0;
        @(negedge CLK);
        while (page_fault || dram_busy) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("memory or fault release");
            end
            @(negedge CLK);
        end
        res_data = insn_data;
    endtask

    task automatic expect_load(input xlen_t va, input xlen_t pa, input xlen_t data, input int ptes);
        do_access(ACCESS_READ, va, '0);
        check_flag(res_fault, 1'b0, "load page fault");
        check_flag(res_le, 1'b1, "load strobe");
        check_word(res_addr, pa, "load address");
        check_ctrl(res_ctrl, FUNCT3_LW, "load size");
        check_word(res_data, data, "load data");
        check_word(xlen_t'(res_ptes), xlen_t'(ptes), "PTE reads before load");
    endtask

    task automatic expect_fetch(input xlen_t va, input xlen_t pa, input xlen_t data);
        do_access(ACCESS_CODE, va, '0);
        check_flag(res_fault, 1'b0, "fetch page fault");
        check_flag(res_le, 1'b1, "fetch strobe");
        check_word(res_addr, pa, "fetch address");
        check_ctrl(res_ctrl, FUNCT3_LW, "fetch size");
        check_word(res_data, data, "fetch data");
    endtask

    task automatic expect_store(input xlen_t va, input xlen_t wd, input xlen_t pa);
        do_access(ACCESS_WRITE, va, wd);
        check_flag(res_fault, 1'b0, "store page fault");
        check_flag(res_we, 1'b1, "store strobe");
        check_word(res_addr, pa, "store address");
        check_word(res_wdata, wd, "store data");
        check_ctrl(res_ctrl, FUNCT3_LW, "store size");
        check_word(mem0.peek(pa), wd, "stored word");
    endtask

    task automatic expect_fault(input access_t kind, input xlen_t va, input cause_t cause);
        do_access(kind, va, '0);
        check_flag(res_fault, 1'b1, "page fault");
        check_cause(res_cause, cause, "fault cause");
    endtask

    task automatic build_tables();
        mem0.poke(ROOT_PA + 32'h4, pte_of(20'h00011, F_V));
        // megapage at va 0x00800000 onto pa 0x00400000
        mem0.poke(ROOT_PA + 32'h8, pte_of(20'h00400, F_V | F_R | F_W | F_X | F_A | F_D));
        mem0.poke(L0_PA + 32'h04, pte_of(20'h00080, F_V | F_R | F_W | F_A | F_D));
        mem0.poke(L0_PA + 32'h08, pte_of(20'h00081, F_V | F_R | F_A));
        mem0.poke(L0_PA + 32'h10, pte_of(20'h00084, F_V | F_R | F_W | F_U | F_A | F_D));
        mem0.poke(L0_PA + 32'h14, pte_of(20'h00085, F_V | F_X | F_A));
        mem0.poke(L0_PA + 32'h18, pte_of(20'h00086, F_V | F_R | F_W));
        mem0.poke(L0_PA + 32'h1c, pte_of(20'h00087, F_V | F_R | F_W));
    endtask

    task automatic test_bypass();
        test_name = "bypass";
        mem0.poke(32'h0000_3000, 32'hcafe_0001);
        set_mode(PRIV_M, SATP_ON, '0);
        expect_load(32'h0000_3000, 32'h0000_3000, 32'hcafe_0001, 0);
        expect_fetch(32'h0000_3000, 32'h0000_3000, 32'hcafe_0001);
        expect_store(32'h0000_3004, 32'h1234_5678, 32'h0000_3004);
        set_mode(PRIV_S, '0, '0);
        expect_load(32'h0000_3004, 32'h0000_3004, 32'h1234_5678, 0);
        expect_store(32'h0000_3008, 32'h0bad_f00d, 32'h0000_3008);
    endtask

    task automatic test_translate();
        test_name = "translate_4k";
        mem0.poke(32'h0008_0234, 32'h1111_2222);
        mem0.poke(32'h0008_0238, 32'h3333_4444);
        set_mode(PRIV_S, SATP_ON, '0);
        expect_load(32'h0040_1234, 32'h0008_0234, 32'h1111_2222, 2);
        // second access hits the TLB
        expect_load(32'h0040_1238, 32'h0008_0238, 32'h3333_4444, 0);
    endtask

    task automatic test_flush();
        test_name = "flush";
        mem0.poke(L0_PA + 32'h04, pte_of(20'h00090, F_V | F_R | F_W | F_A | F_D));
        mem0.poke(32'h0009_0234, 32'h5555_6666);
        expect_load(32'h0040_1234, 32'h0008_0234, 32'h1111_2222, 0);
        @(posedge CLK);
        tlb_flush <= 1'b1;
        @(posedge CLK);
        tlb_flush <= 1'b0;
        expect_load(32'h0040_1234, 32'h0009_0234, 32'h5555_6666, 2);
    endtask

    task automatic test_megapage();
        test_name = "megapage";
        mem0.poke(32'h0040_5678, 32'h7777_8888);
        expect_load(32'h0080_5678, {10'h001, 22'h00_5678}, 32'h7777_8888, 1);
    endtask

    task automatic test_faults();
        test_name = "faults";
        mem0.poke(32'h0008_4010, 32'h9999_aaaa);
        mem0.poke(32'h0008_5020, 32'hbbbb_cccc);
        expect_fault(ACCESS_WRITE, 32'h0040_2000, CAUSE_STORE_PF);
        expect_fault(ACCESS_CODE, 32'h0040_1000, CAUSE_FETCH_PF);
        expect_fault(ACCESS_READ, 32'h0040_4010, CAUSE_LOAD_PF);
        set_mode(PRIV_S, SATP_ON, 32'h1 << MSTATUS_SUM);
        expect_load(32'h0040_4010, 32'h0008_4010, 32'h9999_aaaa, 2);
        // execute-only page is readable only with mxr
        set_mode(PRIV_S, SATP_ON, '0);
        expect_fault(ACCESS_READ, 32'h0040_5020, CAUSE_LOAD_PF);
        set_mode(PRIV_S, SATP_ON, 32'h1 << MSTATUS_MXR);
        expect_load(32'h0040_5020, 32'h0008_5020, 32'hbbbb_cccc, 2);
        set_mode(PRIV_S, SATP_ON, '0);
    endtask

    task automatic test_access_dirty();
        test_name = "access_dirty";
        expect_store(32'h0040_6010, 32'h0000_abcd, 32'h0008_6010);
        check_word(mem0.peek(L0_PA + 32'h18),
                   pte_of(20'h00086, F_V | F_R | F_W | F_A | F_D), "PTE after store");
        mem0.poke(32'h0008_7000, 32'hdddd_eeee);
        expect_load(32'h0040_7000, 32'h0008_7000, 32'hdddd_eeee, 2);
        check_word(mem0.peek(L0_PA + 32'h1c),
                   pte_of(20'h00087, F_V | F_R | F_W | F_A), "PTE after load");
    endtask

    initial begin
        arst_n     = 1'b0;
        access     = ACCESS_NONE;
        insn_addr  = '0;
        data_addr  = '0;
        data_wdata = '0;
        data_we    = 1'b0;
        data_ctrl  = FUNCT3_LW;
        priv       = PRIV_M;
        satp       = '0;
        mstatus    = '0;
        tlb_flush  = 1'b0;
        repeat (16) @(posedge CLK);
        arst_n <= 1'b1;
        build_tables();
        test_bypass();
        test_translate();
        test_flush();
        test_megapage();
        test_faults();
        test_access_dirty();
        finish_run();
    end

endmodule

//--- tb.f
hdl/mmu_pkg.sv
hdl/pte_mem_if.sv
hdl/tlb_fill_if.sv
hdl/xlat_lookup.sv
hdl/pte_check.sv
hdl/page_walker.sv
hdl/dram_port.sv
hdl/sv32_mmu.sv
tests/tb_dram_model.sv
tests/tb_sv32_mmu.sv
